// File: cons_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module cons_crc32 (
	input  wire                         sys_clk,
	input  wire                         glbl_rst_n,
	input  wire                         crc_init,
	input  cons_load_pkg::flash_rsp_t   flash_rsp,
	input  wire                         crc_last_d,
	output logic                        crc_check_ok,
	output logic [31:0]                 crc_value
);

	logic [31:0] crc_reg;
	logic [31:0] tail_sr;

	// Reflected CRC-32, one byte, LSB first
	function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		c = crc ^ {24'd0, data};
		for (int i = 0; i < 8; i++)
		begin
			if (c[0])
				c = (c >> 1) ^ 32'hEDB8_8320;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			crc_reg <= '1;
		else if (crc_init)
			crc_reg <= '1;
		else if (flash_rsp.valid)
			crc_reg <= crc32_byte(crc_reg, flash_rsp.data);
	end

	// Last four bytes seen, the stored CRC once the block ends
	always_ff @(posedge sys_clk)
	begin
		if (flash_rsp.valid)
			tail_sr <= {flash_rsp.data, tail_sr[31:8]};
	end

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			crc_check_ok <= 1'b0;
		else if (crc_init)
			crc_check_ok <= 1'b0;
		else if (crc_last_d)
			crc_check_ok <= (crc_reg == cons_load_pkg::crc_residue);
	end

	always_ff @(posedge sys_clk)
	begin
		if (crc_last_d)
			crc_value <= tail_sr;
	end

endmodule

`default_nettype wire

// File: cons_load_pkg.sv
`default_nettype none

package cons_load_pkg;

	////////////////////////////////////////////////////////////
	// Flash read interface
	////////////////////////////////////////////////////////////

	// Read request, rden is a one-cycle strobe
	typedef struct packed {
		logic        rden;
		logic [23:0] length;
		logic [24:0] addr;
	} flash_req_t;

	// One byte of the read stream
	typedef struct packed {
		logic       valid;
		logic       last;
		logic [7:0] data;
	} flash_rsp_t;

	////////////////////////////////////////////////////////////
	// Constant RAM and parameters
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic        wren;
		logic [15:0] addr;
		logic [7:0]  data;
	} ram_wr_t;

	// Word 0 holds the first four bytes, little-endian
	typedef struct packed {
		logic [31:0] word5;
		logic [31:0] word4;
		logic [31:0] word3;
		logic [31:0] word2;
		logic [31:0] word1;
		logic [31:0] word0;
	} cons_para_t;

	localparam int          para_len        = 24;
	localparam logic [24:0] para_flash_addr = 25'h000_0400;

	// Register value after data plus its own CRC, before inversion
	localparam logic [31:0] crc_residue     = 32'hDEBB_20E3;

endpackage

`default_nettype wire

// File: cons_load_top.f
cons_load_pkg.sv
cons_crc32.sv
cons_loader.sv
cons_ram.sv
cons_para_regs.sv
cons_load_top.sv
tb_cons_load_top.sv

// File: cons_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module cons_load_top #(
	parameter int          cons_len = 900,
	parameter int          ram_aw   = 16,
	parameter logic [31:0] board_id = 32'h1111_1111,
	parameter logic [31:0] code_id  = 32'h2222_2222,
	parameter logic [15:0] id_base  = 16'h0300
) (
	input  wire                         sys_clk,
	input  wire                         glbl_rst_n,
	input  wire                         load_start,
	input  cons_load_pkg::flash_rsp_t   flash_rsp,
	input  wire [ram_aw-1:0]            cons_rd_addr,
	output cons_load_pkg::flash_req_t   flash_req,
	output logic                        load_done,
	output logic                        load_error,
	output logic [7:0]                  cons_rd_data,
	output cons_load_pkg::cons_para_t   cons_para,
	output logic                        para_valid,
	output logic [63:0]                 block_crc
);

	cons_load_pkg::ram_wr_t    ram_wr;
	cons_load_pkg::cons_para_t para_data;
	logic                      crc_init;
	logic                      crc_last_d;
	logic                      crc_check_ok;
	logic [31:0]               crc_value;
	logic                      para_commit;
	logic                      cons_crc_capture;
	logic                      para_crc_capture;

	cons_loader #(
		.cons_len (cons_len),
		.ram_aw   (ram_aw),
		.board_id (board_id),
		.code_id  (code_id),
		.id_base  (id_base)
	) loader0 (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.load_start       (load_start),
		.flash_rsp        (flash_rsp),
		.crc_check_ok     (crc_check_ok),
		.crc_value        (crc_value),
		.flash_req        (flash_req),
		.ram_wr           (ram_wr),
		.crc_init         (crc_init),
		.crc_last_d       (crc_last_d),
		.para_commit      (para_commit),
		.para_data        (para_data),
		.cons_crc_capture (cons_crc_capture),
		.para_crc_capture (para_crc_capture),
		.load_done        (load_done),
		.load_error       (load_error)
	);

	// Runs over the same byte stream the loader sees
	cons_crc32 crc0 (
		.sys_clk      (sys_clk),
		.glbl_rst_n   (glbl_rst_n),
		.crc_init     (crc_init),
		.flash_rsp    (flash_rsp),
		.crc_last_d   (crc_last_d),
		.crc_check_ok (crc_check_ok),
		.crc_value    (crc_value)
	);

	cons_ram #(
		.ram_aw (ram_aw)
	) ram0 (
		.sys_clk      (sys_clk),
		.ram_wr       (ram_wr),
		.cons_rd_addr (cons_rd_addr),
		.cons_rd_data (cons_rd_data)
	);

	cons_para_regs regs0 (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.para_commit      (para_commit),
		.para_data        (para_data),
		.cons_crc_capture (cons_crc_capture),
		.para_crc_capture (para_crc_capture),
		.crc_value        (crc_value),
		.cons_para        (cons_para),
		.para_valid       (para_valid),
		.block_crc        (block_crc)
	);

endmodule

`default_nettype wire

// File: cons_loader.sv
`timescale 1ns/1ps
`default_nettype none

module cons_loader #(
	parameter int          cons_len = 900,
	parameter int          ram_aw   = 16,
	parameter logic [31:0] board_id = 32'h1111_1111,
	parameter logic [31:0] code_id  = 32'h2222_2222,
	parameter logic [15:0] id_base  = 16'h0300
) (
	input  wire                         sys_clk,
	input  wire                         glbl_rst_n,
	input  wire                         load_start,
	input  cons_load_pkg::flash_rsp_t   flash_rsp,
	input  wire                         crc_check_ok,
	input  wire [31:0]                  crc_value,
	output cons_load_pkg::flash_req_t   flash_req,
	output cons_load_pkg::ram_wr_t      ram_wr,
	output logic                        crc_init,
	output logic                        crc_last_d,
	output logic                        para_commit,
	output cons_load_pkg::cons_para_t   para_data,
	output logic                        cons_crc_capture,
	output logic                        para_crc_capture,
	output logic                        load_done,
	output logic                        load_error
);

	localparam logic [3:0] ST_IDLE = 4'd0;
	localparam logic [3:0] ST_CONS = 4'd1;
	localparam logic [3:0] ST_PARA = 4'd2;
	localparam logic [3:0] ST_ID0  = 4'd3;
	localparam logic [3:0] ST_ID7  = 4'd10;

	logic [3:0]        state;
	logic [ram_aw-1:0] byte_cnt;
	logic [191:0]      para_sr;
	logic              last_d;
	logic              last_dd;
	logic              start_acc;
	logic              in_blk;
	logic              in_id;
	logic              blk_pass;
	logic              cons_pass;
	logic              para_pass;
	logic [2:0]        id_idx;
	logic [63:0]       id_bytes;

	assign id_bytes  = {code_id, board_id};
	assign id_idx    = 3'(state - ST_ID0);
	assign in_id     = (state >= ST_ID0) && (state <= ST_ID7);
	assign in_blk    = (state == ST_CONS) || (state == ST_PARA);
	assign start_acc = (state == ST_IDLE) && load_start;

	// Erased flash reads all ones, never a valid stored CRC
	assign blk_pass  = last_dd && crc_check_ok && (crc_value != '1);
	assign cons_pass = (state == ST_CONS) && blk_pass;
	assign para_pass = (state == ST_PARA) && blk_pass;

	assign crc_init         = start_acc || cons_pass;
	assign crc_last_d       = last_d;
	assign cons_crc_capture = cons_pass;
	assign para_crc_capture = para_pass;
	assign para_commit      = para_pass;
	assign para_data        = para_sr;
	assign load_error       = in_blk && last_dd && !blk_pass;
	assign load_done        = (state == ST_ID7);

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state    <= ST_IDLE;
			byte_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					byte_cnt <= '0;
					if (load_start)
						state <= ST_CONS;
				end
				ST_CONS:
				begin
					if (last_dd)
					begin
						byte_cnt <= '0;
						state    <= blk_pass ? ST_PARA : ST_IDLE;
					end
					else if (flash_rsp.valid)
						byte_cnt <= byte_cnt + 1'b1;
				end
				ST_PARA:
				begin
					if (last_dd)
						state <= blk_pass ? ST_ID0 : ST_IDLE;
					else if (flash_rsp.valid && (byte_cnt < cons_load_pkg::para_len))
						byte_cnt <= byte_cnt + 1'b1;
				end
				ST_ID7:
					state <= ST_IDLE;
				default:
				begin
					if (in_id)
						state <= state + 4'd1;
					else
						state <= ST_IDLE;
				end
			endcase
		end
	end

	// Parameter bytes shift in from the top, first byte ends at bit 0
	always_ff @(posedge sys_clk)
	begin
		if ((state == ST_PARA) && flash_rsp.valid && !last_dd
			&& (byte_cnt < cons_load_pkg::para_len))
			para_sr <= {flash_rsp.data, para_sr[191:8]};
	end

	// Last delayed twice, the check result is ready on the second
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			last_d  <= 1'b0;
			last_dd <= 1'b0;
		end
		else
		begin
			last_d  <= flash_rsp.valid && flash_rsp.last && (state != ST_IDLE);
			last_dd <= last_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Flash requests and RAM writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			flash_req <= '0;
		else if (start_acc)
		begin
			flash_req.rden   <= 1'b1;
			flash_req.length <= 24'(cons_len);
			flash_req.addr   <= '0;
		end
		else if (cons_pass)
		begin
			flash_req.rden   <= 1'b1;
			flash_req.length <= 24'(cons_load_pkg::para_len + 4);
			flash_req.addr   <= cons_load_pkg::para_flash_addr;
		end
		else
			flash_req.rden <= 1'b0;
	end

	always_comb
	begin
		ram_wr = '0;
		if (state == ST_CONS)
		begin
			ram_wr.wren = flash_rsp.valid;
			ram_wr.addr = 16'(byte_cnt);
			ram_wr.data = flash_rsp.data;
		end
		else if (in_id)
		begin
			// Board ID then code ID, low byte first
			ram_wr.wren = 1'b1;
			ram_wr.addr = id_base + {13'd0, id_idx};
			ram_wr.data = id_bytes[id_idx*8 +: 8];
		end
	end

endmodule

`default_nettype wire

// File: cons_para_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cons_para_regs (
	input  wire                         sys_clk,
	input  wire                         glbl_rst_n,
	input  wire                         para_commit,
	input  cons_load_pkg::cons_para_t   para_data,
	input  wire                         cons_crc_capture,
	input  wire                         para_crc_capture,
	input  wire [31:0]                  crc_value,
	output cons_load_pkg::cons_para_t   cons_para,
	output logic                        para_valid,
	output logic [63:0]                 block_crc
);

	////////////////////////////////////////////////////////////
	// Committed parameter set
	////////////////////////////////////////////////////////////

	// Held across failed loads
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			cons_para  <= '0;
			para_valid <= 1'b0;
		end
		else if (para_commit)
		begin
			cons_para  <= para_data;
			para_valid <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Block CRC status
	////////////////////////////////////////////////////////////

	// Parameter CRC upper, constant CRC lower
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			block_crc <= '0;
		else
		begin
			if (cons_crc_capture)
				block_crc[31:0] <= crc_value;
			if (para_crc_capture)
				block_crc[63:32] <= crc_value;
		end
	end

endmodule

`default_nettype wire

// File: cons_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cons_ram #(
	parameter int ram_aw = 16
) (
	input  wire                         sys_clk,
	input  cons_load_pkg::ram_wr_t      ram_wr,
	input  wire [ram_aw-1:0]            cons_rd_addr,
	output logic [7:0]                  cons_rd_data
);

	logic [7:0] mem [2**ram_aw];

	// Write side, byte at a time from the loader
	always_ff @(posedge sys_clk)
	begin
		if (ram_wr.wren)
			mem[ram_wr.addr[ram_aw-1:0]] <= ram_wr.data;
	end

	// Registered read, one cycle latency
	always_ff @(posedge sys_clk)
	begin
		cons_rd_data <= mem[cons_rd_addr];
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f cons_load_top.f \
	--top-module tb_cons_load_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Some tests failed" sim.log; then
	echo "Simulation failed"
	exit 1
fi
grep -q "All tests passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tb_cons_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cons_load_top;

	localparam int          cons_len     = 900;
	localparam logic [15:0] id_base      = 16'h0300;
	localparam logic [31:0] board_id_exp = 32'h1111_1111;
	localparam logic [31:0] code_id_exp  = 32'h2222_2222;
	localparam int          para_blk_len = cons_load_pkg::para_len + 4;
	localparam int          max_cycles   = 20000;

	logic                      sys_clk;
	logic                      glbl_rst_n;
	logic                      load_start;
	cons_load_pkg::flash_rsp_t flash_rsp;
	logic [15:0]               cons_rd_addr;
	cons_load_pkg::flash_req_t flash_req;
	logic                      load_done;
	logic                      load_error;
	logic [7:0]                cons_rd_data;
	cons_load_pkg::cons_para_t cons_para;
	logic                      para_valid;
	logic [63:0]               block_crc;

	logic [7:0] cons_img [cons_len];
	logic [7:0] para_img [para_blk_len];
	logic       streaming;
	int         error_count = 0;
	int         cycle_count = 0;
	int         req_count;
	int         para_req_count;
	int         done_count;
	int         fail_count;

	cons_load_top dut0 (
		.sys_clk      (sys_clk),
		.glbl_rst_n   (glbl_rst_n),
		.load_start   (load_start),
		.flash_rsp    (flash_rsp),
		.cons_rd_addr (cons_rd_addr),
		.flash_req    (flash_req),
		.load_done    (load_done),
		.load_error   (load_error),
		.cons_rd_data (cons_rd_data),
		.cons_para    (cons_para),
		.para_valid   (para_valid),
		.block_crc    (block_crc)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("** Error: %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	always @(posedge sys_clk)
	begin
		cycle_count++;
		if (cycle_count >= max_cycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Some tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	////////////////////////////////////////////////////////////
	// Reference CRC and flash images
	////////////////////////////////////////////////////////////

	// Reflected CRC-32, one data bit per step
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] data);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int b = 0; b < 8; b++)
		begin
			fb = c[0] ^ data[b];
			c  = {1'b0, c[31:1]};
			if (fb)
				c = c ^ 32'hEDB8_8320;
		end
		return c;
	endfunction

	task automatic build_images(input bit bad_cons, input bit bad_para);
		logic [31:0] c;
		int          i;
		c = '1;
		for (i = 0; i < cons_len - 4; i++)
		begin
			cons_img[i] = 8'($urandom);
			c = crc_update(c, cons_img[i]);
		end
		c = ~c;
		for (i = 0; i < 4; i++)
			cons_img[cons_len-4+i] = c[8*i +: 8];
		if (bad_cons)
			cons_img[cons_len-3] ^= 8'h5a;
		c = '1;
		for (i = 0; i < cons_load_pkg::para_len; i++)
		begin
			para_img[i] = 8'($urandom);
			c = crc_update(c, para_img[i]);
		end
		c = ~c;
		for (i = 0; i < 4; i++)
			para_img[cons_load_pkg::para_len+i] = c[8*i +: 8];
		if (bad_para)
			para_img[para_blk_len-1] ^= 8'h81;
	endtask

	function automatic logic [31:0] cons_stored_crc();
		return {cons_img[cons_len-1], cons_img[cons_len-2], cons_img[cons_len-3],
			cons_img[cons_len-4]};
	endfunction

	function automatic logic [31:0] para_stored_crc();
		return {para_img[para_blk_len-1], para_img[para_blk_len-2], para_img[para_blk_len-3],
			para_img[para_blk_len-4]};
	endfunction

	// Byte i lands at bits 8i, so word 0 holds the first four
	function automatic logic [191:0] para_expected();
		logic [191:0] p;
		p = '0;
		for (int i = 0; i < cons_load_pkg::para_len; i++)
			p[8*i +: 8] = para_img[i];
		return p;
	endfunction

	function automatic logic [7:0] image_byte(input logic [24:0] addr, input int i);
		if (addr == '0)
			return cons_img[i];
		else if (addr == cons_load_pkg::para_flash_addr)
			return para_img[i];
		return 8'hff;
	endfunction

	////////////////////////////////////////////////////////////
	// Flash model and monitors
	////////////////////////////////////////////////////////////

	initial
	begin
		int          n;
		int          gap;
		logic [24:0] addr;
		flash_rsp = '0;
		streaming = 1'b0;
		forever
		begin
			@(posedge sys_clk);
			#10;
			if (glbl_rst_n && flash_req.rden)
			begin
				n         = int'(flash_req.length);
				addr      = flash_req.addr;
				streaming = 1'b1;
				for (int i = 0; i < n; i++)
				begin
					gap = int'($urandom_range(3, 0));
					repeat (gap)
					begin
						flash_rsp = '0;
						@(posedge sys_clk);
						#10;
					end
					flash_rsp.valid = 1'b1;
					flash_rsp.last  = (i == n - 1);
					flash_rsp.data  = image_byte(addr, i);
					@(posedge sys_clk);
					#10;
				end
				flash_rsp = '0;
				streaming = 1'b0;
			end
		end
	end

	// Counts pulses away from the driving edge
	always @(negedge sys_clk)
	begin
		if (glbl_rst_n)
		begin
			if (flash_req.rden)
			begin
				req_count++;
				if (flash_req.addr == cons_load_pkg::para_flash_addr)
				begin
					para_req_count++;
					assert (flash_req.length == 24'(para_blk_len))
					else report_error("parameter request with wrong length");
				end
				else
					assert (flash_req.addr == '0 && flash_req.length == 24'(cons_len))
					else report_error("constant request with wrong address or length");
			end
			if (load_done)
				done_count++;
			if (load_error)
				fail_count++;
		end
	end

	rden_single: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		flash_req.rden |=> !flash_req.rden)
		else report_error("flash request strobe held longer than one cycle");

	// The model raises streaming only after it has seen the strobe
	no_req_in_stream: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		!(flash_req.rden && $past(streaming)))
		else report_error("flash request issued while a block was streaming");

	done_or_error: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		!(load_done && load_error))
		else report_error("load_done and load_error high together");

	////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////

	task automatic run_load(input bit restart_mid);
		req_count      = 0;
		para_req_count = 0;
		done_count     = 0;
		fail_count     = 0;
		load_start     = 1'b1;
		@(posedge sys_clk);
		#10;
		load_start = 1'b0;
		assert (flash_req.rden && flash_req.length == 24'(cons_len) && flash_req.addr == '0)
		else report_error("constant request missing one cycle after load_start");
		if (restart_mid)
		begin
			repeat (300)
			begin
				@(posedge sys_clk);
				#10;
			end
			load_start = 1'b1;
			@(posedge sys_clk);
			#10;
			load_start = 1'b0;
		end
		while (!load_done && !load_error)
		begin
			@(posedge sys_clk);
			#10;
		end
		// Quiet tail to catch stray pulses
		repeat (8)
		begin
			@(posedge sys_clk);
			#10;
		end
	endtask

	task automatic check_counts(input int done_n, input int err_n,
		input int req_n, input int para_n);
		assert (done_count == done_n && fail_count == err_n)
		else report_error($sformatf("done/error pulses %0d/%0d, expected %0d/%0d",
			done_count, fail_count, done_n, err_n));
		assert (req_count == req_n && para_req_count == para_n)
		else report_error($sformatf("requests %0d (parameter %0d), expected %0d (%0d)",
			req_count, para_req_count, req_n, para_n));
	endtask

	// One address per cycle, data one cycle behind
	task automatic check_ram(input bit with_ids);
		logic [63:0] ids;
		logic [7:0]  exp;
		ids          = {code_id_exp, board_id_exp};
		cons_rd_addr = '0;
		for (int a = 0; a < cons_len; a++)
		begin
			@(posedge sys_clk);
			#10;
			exp = cons_img[a];
			if (with_ids && a >= id_base && a < id_base + 8)
				exp = ids[(a - id_base)*8 +: 8];
			assert (cons_rd_data == exp)
			else report_error($sformatf("RAM byte %0d reads %02h, expected %02h",
				a, cons_rd_data, exp));
			if (a + 1 < cons_len)
				cons_rd_addr = 16'(a + 1);
		end
	endtask

	task automatic check_good_load();
		check_counts(1, 0, 2, 1);
		check_ram(1'b1);
		assert (para_valid && cons_para == para_expected())
		else report_error("committed parameters differ from the image");
		assert (block_crc == {para_stored_crc(), cons_stored_crc()})
		else report_error($sformatf("block_crc %016h is wrong", block_crc));
	endtask

	initial
	begin
		logic [191:0] prev_para;
		logic [63:0]  prev_crc;
		void'($urandom(32'hba5a_0c74));
		glbl_rst_n   = 1'b0;
		load_start   = 1'b0;
		cons_rd_addr = '0;
		repeat (2) @(posedge sys_clk);
		#10;
		glbl_rst_n = 1'b1;
		assert (!flash_req.rden && !load_done && !load_error && !para_valid && block_crc == '0)
		else report_error("outputs not low after reset");

		// Good load
		build_images(1'b0, 1'b0);
		run_load(1'b0);
		check_good_load();
		prev_para = para_expected();
		prev_crc  = {para_stored_crc(), cons_stored_crc()};

		// Bad constant CRC, stream bytes stay and nothing else moves
		build_images(1'b1, 1'b0);
		run_load(1'b0);
		check_counts(0, 1, 1, 0);
		assert (para_valid && cons_para == prev_para && block_crc == prev_crc)
		else report_error("parameter registers changed after a failed constant block");
		check_ram(1'b0);

		// Good constant block, bad parameter CRC
		build_images(1'b0, 1'b1);
		run_load(1'b0);
		check_counts(0, 1, 2, 1);
		assert (para_valid && cons_para == prev_para)
		else report_error("parameters changed after a failed parameter block");
		assert (block_crc == {prev_crc[63:32], cons_stored_crc()})
		else report_error($sformatf("block_crc %016h is wrong", block_crc));
		check_ram(1'b0);

		// Second start strobe while busy
		build_images(1'b0, 1'b0);
		run_load(1'b1);
		check_good_load();

		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
